//--- source/core_pkg.sv
// Sizes are fixed for 4 channels of 16 registers; the instruction store must not exceed 1024 words
`default_nettype none

package core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int data_width = 32;
    localparam int instruction_width = 32;
    localparam int max_channels = 4;
    localparam int channel_width = 2;
    localparam int registers_per_channel = 16;
    localparam int register_index_width = 4;
    localparam int register_address_width = 6;
    localparam int register_count = max_channels * registers_per_channel;
    // Issue to register write, in cycles
    localparam int pipeline_depth = 3;
    localparam int bus_address_width = 12;

    // Wishbone word address map
    localparam logic [bus_address_width-1:0] store_base = 12'h000;
    localparam logic [bus_address_width-1:0] register_base = 12'h400;
    localparam logic [bus_address_width-1:0] channel_count_address = 12'h800;
    localparam logic [bus_address_width-1:0] status_address = 12'h801;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        nop, add, sub, mul, op_and, op_or, op_xor, shl, shr, ldi, stop
    } opcode_t;

    typedef enum logic [1:0] {
        idle, fetch, sweep, drain
    } control_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Records
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [bus_address_width-1:0] adr;
        logic [data_width-1:0] dat;
    } wb_request_t;

    typedef struct packed {
        logic ack;
        logic [data_width-1:0] dat;
    } wb_response_t;

    typedef struct packed {
        logic valid;
        opcode_t opcode;
        logic [register_address_width-1:0] destination;
        logic [register_address_width-1:0] source_a;
        logic [register_address_width-1:0] source_b;
        logic [data_width-1:0] immediate;
    } issue_t;

    typedef struct packed {
        logic valid;
        opcode_t opcode;
        logic [register_address_width-1:0] destination;
        logic [data_width-1:0] operand_a;
        logic [data_width-1:0] operand_b;
        logic [data_width-1:0] immediate;
    } operand_t;

    typedef struct packed {
        logic valid;
        logic [register_address_width-1:0] address;
        logic [data_width-1:0] data;
    } writeback_t;

endpackage

`default_nettype wire

//--- source/core_control_unit.sv
// A run pulse is taken only while idle; channel_count is minus-one coded and read every sweep
`timescale 1ns/100ps
`default_nettype none

module core_control_unit import core_pkg::*; #(
    parameter int INSTRUCTION_STORE_SIZE = 256
) (
    input  logic clock,
    input  logic reset,
    input  logic run,
    input  logic [channel_width-1:0] channel_count,
    input  logic stop_seen,
    output logic [$clog2(INSTRUCTION_STORE_SIZE)-1:0] fetch_address,
    output logic slot_valid,
    output logic [channel_width-1:0] slot_channel,
    output logic busy,
    output logic done
);

    // One extra bit so the slot counter can reach the padded length
    localparam int slot_width = channel_width + 1;

    control_state_t state;
    logic [slot_width-1:0] slot;
    logic [slot_width-1:0] active_channels;
    logic [slot_width-1:0] slot_total;

    assign active_channels = slot_width'(channel_count) + slot_width'(1);

    // Short sweeps are padded so a channel is never read before its last write
    assign slot_total = (active_channels > slot_width'(pipeline_depth)) ?
                        active_channels : slot_width'(pipeline_depth);

    assign slot_valid = (state == sweep) && (slot < active_channels);
    assign slot_channel = slot[channel_width-1:0];
    assign busy = (state != idle);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            slot <= '0;
            fetch_address <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (run) begin
                        fetch_address <= '0;
                        slot <= '0;
                        state <= fetch;
                    end
                end
                fetch: begin
                    state <= sweep;
                end
                sweep: begin
                    if (stop_seen) begin
                        slot <= '0;
                        state <= drain;
                    end else if (slot == slot_total - slot_width'(1)) begin
                        slot <= '0;
                        fetch_address <= fetch_address + 1'b1;
                        state <= fetch;
                    end else begin
                        slot <= slot + slot_width'(1);
                    end
                end
                drain: begin
                    // Wait for the last writeback to land
                    if (slot == slot_width'(pipeline_depth - 1)) begin
                        state <= idle;
                        done <= 1'b1;
                    end else begin
                        slot <= slot + slot_width'(1);
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/core_instruction_store.sv
// Both ports read one cycle late; a bus write and a fetch of the same word return the old word
`timescale 1ns/100ps
`default_nettype none

module core_instruction_store import core_pkg::*; #(
    parameter int INSTRUCTION_STORE_SIZE = 256
) (
    input  logic clock,
    input  logic reset,
    input  logic [$clog2(INSTRUCTION_STORE_SIZE)-1:0] fetch_address,
    output logic [instruction_width-1:0] instruction,
    input  logic bus_enable,
    input  logic bus_write,
    input  logic [$clog2(INSTRUCTION_STORE_SIZE)-1:0] bus_address,
    input  logic [instruction_width-1:0] bus_write_data,
    output logic [instruction_width-1:0] bus_read_data
);

    logic [instruction_width-1:0] memory [INSTRUCTION_STORE_SIZE];

    // Fetch port
    // The word clears to nop so the decoder starts quiet
    always_ff @(posedge clock) begin
        if (reset) begin
            instruction <= '0;
        end else begin
            instruction <= memory[fetch_address];
        end
    end

    // Bus port
    always_ff @(posedge clock) begin
        if (bus_enable) begin
            if (bus_write) begin
                memory[bus_address] <= bus_write_data;
            end else begin
                bus_read_data <= memory[bus_address];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/core_decoder.sv
// Opcodes outside opcode_t pass through and are dropped by the ALU; stop is only honoured in slot 0
`timescale 1ns/100ps
`default_nettype none

module core_decoder import core_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic [instruction_width-1:0] instruction,
    input  logic slot_valid,
    input  logic [channel_width-1:0] slot_channel,
    output issue_t issue,
    output logic stop_seen
);

    opcode_t opcode;
    logic [register_index_width-1:0] destination_index;
    logic [register_index_width-1:0] source_a_index;
    logic [register_index_width-1:0] source_b_index;

    // Field layout of an instruction word
    assign opcode = opcode_t'(instruction[instruction_width-1 -: $bits(opcode_t)]);
    assign destination_index = instruction[26 -: register_index_width];
    assign source_a_index = instruction[22 -: register_index_width];
    assign source_b_index = instruction[18 -: register_index_width];

    assign stop_seen = slot_valid && (slot_channel == '0) && (opcode == stop);

    always_ff @(posedge clock) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else begin
            // A stop word issues nothing on any channel
            issue.valid <= slot_valid && (opcode != stop);
        end
        issue.opcode <= opcode;

        // Channel number selects the bank
        issue.destination <= {slot_channel, destination_index};
        issue.source_a <= {slot_channel, source_a_index};
        issue.source_b <= {slot_channel, source_b_index};

        // ldi immediate, sign extended
        issue.immediate <= {{(data_width - 16){instruction[15]}}, instruction[15:0]};
    end

endmodule

`default_nettype wire

//--- source/core_register_file.sv
// Bus writes are expected only while the core is idle; ALU writeback wins any collision
`timescale 1ns/100ps
`default_nettype none

module core_register_file import core_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  issue_t issue,
    output operand_t operands,
    input  writeback_t writeback,
    input  logic bus_enable,
    input  logic bus_write,
    input  logic [register_address_width-1:0] bus_address,
    input  logic [data_width-1:0] bus_write_data,
    output logic [data_width-1:0] bus_read_data
);

    logic [data_width-1:0] registers [register_count];

    // Operands are read one cycle after issue
    always_ff @(posedge clock) begin
        if (reset) begin
            operands.valid <= 1'b0;
        end else begin
            operands.valid <= issue.valid;
        end
        operands.opcode <= issue.opcode;
        operands.destination <= issue.destination;
        operands.operand_a <= registers[issue.source_a];
        operands.operand_b <= registers[issue.source_b];
        operands.immediate <= issue.immediate;
    end

    // Single write port shared by results and the bus
    always_ff @(posedge clock) begin
        if (writeback.valid) begin
            registers[writeback.address] <= writeback.data;
        end else if (bus_enable && bus_write) begin
            registers[bus_address] <= bus_write_data;
        end
    end

    always_ff @(posedge clock) begin
        if (bus_enable && !bus_write) begin
            bus_read_data <= registers[bus_address];
        end
    end

endmodule

`default_nettype wire

//--- source/core_alu.sv
// Integer only; shifts are logical and take the low 5 bits of b, mul keeps the low word
`timescale 1ns/100ps
`default_nettype none

module core_alu import core_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  operand_t operands,
    output writeback_t writeback
);

    localparam int shift_width = $clog2(data_width);

    logic [data_width-1:0] result;
    logic writes_result;

    always_comb begin
        result = '0;
        writes_result = 1'b1;
        case (operands.opcode)
            add:     result = operands.operand_a + operands.operand_b;
            sub:     result = operands.operand_a - operands.operand_b;
            mul:     result = operands.operand_a * operands.operand_b;
            op_and:  result = operands.operand_a & operands.operand_b;
            op_or:   result = operands.operand_a | operands.operand_b;
            op_xor:  result = operands.operand_a ^ operands.operand_b;
            shl:     result = operands.operand_a << operands.operand_b[shift_width-1:0];
            shr:     result = operands.operand_a >> operands.operand_b[shift_width-1:0];
            ldi:     result = operands.immediate;
            // nop and anything unknown leave the registers alone
            default: writes_result = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            writeback.valid <= 1'b0;
        end else begin
            writeback.valid <= operands.valid && writes_result;
        end
        writeback.address <= operands.destination;
        writeback.data <= result;
    end

endmodule

`default_nettype wire

//--- source/core_bus_endpoint.sv
// Wishbone classic, full words only; register region accesses stall for as long as the core runs
`timescale 1ns/100ps
`default_nettype none

module core_bus_endpoint import core_pkg::*; #(
    parameter int INSTRUCTION_STORE_SIZE = 256
) (
    input  logic clock,
    input  logic reset,
    input  wb_request_t bus_request,
    output wb_response_t bus_response,
    input  logic busy,
    output logic [channel_width-1:0] channel_count,
    output logic store_enable,
    output logic store_write,
    output logic [$clog2(INSTRUCTION_STORE_SIZE)-1:0] store_address,
    output logic [instruction_width-1:0] store_write_data,
    input  logic [instruction_width-1:0] store_read_data,
    output logic register_enable,
    output logic register_write,
    output logic [register_address_width-1:0] register_address,
    output logic [data_width-1:0] register_write_data,
    input  logic [data_width-1:0] register_read_data
);

    localparam int store_address_width = $clog2(INSTRUCTION_STORE_SIZE);

    logic [bus_address_width-1:0] store_offset;
    logic [bus_address_width-1:0] register_offset;
    logic is_store;
    logic is_register;
    logic is_channel_count;
    logic is_status;
    logic access;
    logic ack;
    logic read_store;
    logic read_register;
    logic read_channel_count;
    logic read_status;
    logic [data_width-1:0] read_data;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    assign store_offset = bus_request.adr - store_base;
    assign register_offset = bus_request.adr - register_base;
    assign is_store = store_offset < bus_address_width'(INSTRUCTION_STORE_SIZE);
    assign is_register = register_offset < bus_address_width'(register_count);
    assign is_channel_count = (bus_request.adr == channel_count_address);
    assign is_status = (bus_request.adr == status_address);

    // Live from stb until ack, held back for the register region while busy
    assign access = bus_request.cyc && bus_request.stb && !ack && !(is_register && busy);

    assign store_enable = access && is_store;
    assign store_write = bus_request.we;
    assign store_address = store_offset[store_address_width-1:0];
    assign store_write_data = bus_request.dat;

    assign register_enable = access && is_register;
    assign register_write = bus_request.we;
    assign register_address = register_offset[register_address_width-1:0];
    assign register_write_data = bus_request.dat;

    ////////////////////////////////////////////////////////////////////////////
    // Ack, channel count and read data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ack <= 1'b0;
            read_store <= 1'b0;
            read_register <= 1'b0;
            read_channel_count <= 1'b0;
            read_status <= 1'b0;
            channel_count <= channel_width'(max_channels - 1);
        end else begin
            ack <= access;
            read_store <= access && !bus_request.we && is_store;
            read_register <= access && !bus_request.we && is_register;
            read_channel_count <= access && !bus_request.we && is_channel_count;
            read_status <= access && !bus_request.we && is_status;
            if (access && bus_request.we && is_channel_count) begin
                channel_count <= bus_request.dat[channel_width-1:0];
            end
        end
    end

    // Unmapped reads fall through to zero
    always_comb begin
        read_data = '0;
        if (read_store) begin
            read_data = store_read_data;
        end else if (read_register) begin
            read_data = register_read_data;
        end else if (read_channel_count) begin
            read_data = data_width'(channel_count);
        end else if (read_status) begin
            read_data = data_width'(busy);
        end
    end

    assign bus_response = '{ack: ack, dat: read_data};

endmodule

`default_nettype wire

//--- source/core_top.sv
// INSTRUCTION_STORE_SIZE must be a power of two no larger than 1024
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; #(
    parameter int INSTRUCTION_STORE_SIZE = 256
) (
    input  logic clock,
    input  logic reset,
    input  logic run,
    output logic done,
    output logic busy,
    input  wb_request_t bus_request,
    output wb_response_t bus_response
);

    localparam int store_address_width = $clog2(INSTRUCTION_STORE_SIZE);

    logic [channel_width-1:0] channel_count;
    logic stop_seen;
    logic slot_valid;
    logic [channel_width-1:0] slot_channel;
    logic [store_address_width-1:0] fetch_address;
    logic [instruction_width-1:0] instruction;
    issue_t issue;
    operand_t operands;
    writeback_t writeback;

    logic store_enable;
    logic store_write;
    logic [store_address_width-1:0] store_address;
    logic [instruction_width-1:0] store_write_data;
    logic [instruction_width-1:0] store_read_data;
    logic register_enable;
    logic register_write;
    logic [register_address_width-1:0] register_address;
    logic [data_width-1:0] register_write_data;
    logic [data_width-1:0] register_read_data;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////////////////////

    core_control_unit #(
        .INSTRUCTION_STORE_SIZE(INSTRUCTION_STORE_SIZE)
    ) control_unit (
        .clock(clock),
        .reset(reset),
        .run(run),
        .channel_count(channel_count),
        .stop_seen(stop_seen),
        .fetch_address(fetch_address),
        .slot_valid(slot_valid),
        .slot_channel(slot_channel),
        .busy(busy),
        .done(done)
    );

    core_decoder decoder (
        .clock(clock),
        .reset(reset),
        .instruction(instruction),
        .slot_valid(slot_valid),
        .slot_channel(slot_channel),
        .issue(issue),
        .stop_seen(stop_seen)
    );

    core_register_file register_file (
        .clock(clock),
        .reset(reset),
        .issue(issue),
        .operands(operands),
        .writeback(writeback),
        .bus_enable(register_enable),
        .bus_write(register_write),
        .bus_address(register_address),
        .bus_write_data(register_write_data),
        .bus_read_data(register_read_data)
    );

    core_alu alu (
        .clock(clock),
        .reset(reset),
        .operands(operands),
        .writeback(writeback)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Program store and bus
    ////////////////////////////////////////////////////////////////////////////

    core_instruction_store #(
        .INSTRUCTION_STORE_SIZE(INSTRUCTION_STORE_SIZE)
    ) instruction_store (
        .clock(clock),
        .reset(reset),
        .fetch_address(fetch_address),
        .instruction(instruction),
        .bus_enable(store_enable),
        .bus_write(store_write),
        .bus_address(store_address),
        .bus_write_data(store_write_data),
        .bus_read_data(store_read_data)
    );

    core_bus_endpoint #(
        .INSTRUCTION_STORE_SIZE(INSTRUCTION_STORE_SIZE)
    ) bus_endpoint (
        .clock(clock),
        .reset(reset),
        .bus_request(bus_request),
        .bus_response(bus_response),
        .busy(busy),
        .channel_count(channel_count),
        .store_enable(store_enable),
        .store_write(store_write),
        .store_address(store_address),
        .store_write_data(store_write_data),
        .store_read_data(store_read_data),
        .register_enable(register_enable),
        .register_write(register_write),
        .register_address(register_address),
        .register_write_data(register_write_data),
        .register_read_data(register_read_data)
    );

endmodule

`default_nettype wire

//--- testbench/core_clock_gen.sv
// Free-running 10 ns clock; reset is high for the first 8 rising edges and drops on a falling edge
`timescale 1ns/100ps
`default_nettype none

module core_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/core_tb.sv
// Needs the 256-word store of core_top; all stimulus comes from one fixed seed
`timescale 1ns/100ps
`default_nettype none

module core_tb import core_pkg::*; ();

    localparam int store_size = 256;
    localparam int program_count = 20;
    localparam int min_program_length = 4;
    localparam int max_program_length = 20;
    localparam int store_samples = 16;
    // Bus time per program, in cycles
    localparam int bus_cycles_per_program = 200;
    localparam int timeout_cycles =
        program_count * (max_program_length * 5 + bus_cycles_per_program) * 2;

    logic clock;
    logic reset;
    logic run;
    logic done;
    logic busy;
    wb_request_t bus_request;
    wb_response_t bus_response;

    integer seed;
    int data_errors = 0;
    int store_errors = 0;
    int flag_errors = 0;
    int other_errors = 0;
    int done_count = 0;

    logic [data_width-1:0] model_registers [register_count];
    logic [instruction_width-1:0] store_model [store_size];
    logic [instruction_width-1:0] program_words [max_program_length + 1];

    core_clock_gen clock_gen (
        .clock(clock),
        .reset(reset)
    );

    core_top #(
        .INSTRUCTION_STORE_SIZE(store_size)
    ) core_top_inst (
        .clock(clock),
        .reset(reset),
        .run(run),
        .done(done),
        .busy(busy),
        .bus_request(bus_request),
        .bus_response(bus_response)
    );

    // Every cycle with done high counts as one pulse
    always @(negedge clock) begin
        if (!reset && done) begin
            done_count++;
        end
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("Test failures found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_data(input string name, input logic [data_width-1:0] actual,
                              input logic [data_width-1:0] expected);
        if (actual !== expected) begin
            data_errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic check_opcode_trace(input string name,
                                      input logic [instruction_width-1:0] actual,
                                      input logic [instruction_width-1:0] expected);
        opcode_t actual_opcode;
        opcode_t expected_opcode;
        actual_opcode = opcode_t'(actual[31:27]);
        expected_opcode = opcode_t'(expected[31:27]);
        if (actual !== expected) begin
            store_errors++;
            $display("Mismatch %s: got 0x%h (%s), expected 0x%h (%s)", name, actual,
                     actual_opcode.name(), expected, expected_opcode.name());
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            flag_errors++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    task automatic report_failure(input string text);
        other_errors++;
        $display("Error: %s", text);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    // Called on a falling edge, returns on a falling edge after one idle cycle
    task automatic bus_transfer(input logic write, input logic [bus_address_width-1:0] address,
                                input logic [data_width-1:0] write_data,
                                output logic [data_width-1:0] read_data);
        bus_request.cyc = 1'b1;
        bus_request.stb = 1'b1;
        bus_request.we = write;
        bus_request.adr = address;
        bus_request.dat = write_data;
        do begin
            @(negedge clock);
        end while (!bus_response.ack);
        read_data = bus_response.dat;
        bus_request.cyc = 1'b0;
        bus_request.stb = 1'b0;
        bus_request.we = 1'b0;
        @(negedge clock);
    endtask

    task automatic bus_write(input logic [bus_address_width-1:0] address,
                             input logic [data_width-1:0] data);
        logic [data_width-1:0] ignored;
        bus_transfer(1'b1, address, data, ignored);
    endtask

    task automatic bus_read(input logic [bus_address_width-1:0] address,
                            output logic [data_width-1:0] data);
        bus_transfer(1'b0, address, '0, data);
    endtask

    task automatic pulse_run();
        run = 1'b1;
        @(negedge clock);
        run = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Each word runs on every active channel in its own bank
    task automatic execute_model(input int length, input int active_channels);
        logic [instruction_width-1:0] word;
        opcode_t op;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        logic [data_width-1:0] immediate;
        int destination;
        int bank;
        for (int i = 0; i < length; i++) begin
            word = program_words[i];
            op = opcode_t'(word[31:27]);
            immediate = {{16{word[15]}}, word[15:0]};
            for (int channel = 0; channel < active_channels; channel++) begin
                bank = channel * registers_per_channel;
                destination = bank + int'(word[26:23]);
                a = model_registers[bank + int'(word[22:19])];
                b = model_registers[bank + int'(word[18:15])];
                case (op)
                    add: model_registers[destination] = a + b;
                    sub: model_registers[destination] = a - b;
                    mul: model_registers[destination] = a * b;
                    op_and: model_registers[destination] = a & b;
                    op_or: model_registers[destination] = a | b;
                    op_xor: model_registers[destination] = a ^ b;
                    shl: model_registers[destination] = a << b[4:0];
                    shr: model_registers[destination] = a >> b[4:0];
                    ldi: model_registers[destination] = immediate;
                    default: ;
                endcase
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic bus_round_trip();
        int addresses [store_samples];
        logic [data_width-1:0] value;
        logic [data_width-1:0] written;
        // Four channels are active out of reset
        bus_read(channel_count_address, value);
        check_data("channel_count after reset", value, 32'd3);
        for (int i = 0; i < store_samples; i++) begin
            addresses[i] = int'(random_word() % store_size);
            value = random_word();
            store_model[addresses[i]] = value;
            bus_write(store_base + bus_address_width'(addresses[i]), value);
        end
        // Repeated addresses hold the last word written
        for (int i = 0; i < store_samples; i++) begin
            bus_read(store_base + bus_address_width'(addresses[i]), value);
            check_opcode_trace($sformatf("store[%0d]", addresses[i]), value,
                               store_model[addresses[i]]);
        end
        for (int i = 0; i < register_count; i++) begin
            model_registers[i] = random_word();
            bus_write(register_base + bus_address_width'(i), model_registers[i]);
        end
        for (int i = 0; i < register_count; i++) begin
            bus_read(register_base + bus_address_width'(i), value);
            check_data($sformatf("register[%0d]", i), value, model_registers[i]);
        end
        // Unmapped space
        bus_write(12'h300, random_word());
        bus_read(12'h300, value);
        check_data("unmapped 0x300", value, '0);
        bus_read(12'ha00, value);
        check_data("unmapped 0xa00", value, '0);
        written = random_word();
        bus_write(channel_count_address, written);
        bus_read(channel_count_address, value);
        check_data("channel_count", value, data_width'(written[channel_width-1:0]));
    endtask

    task automatic run_program(input int index);
        int active_channels;
        int length;
        int done_before;
        int watched;
        logic [data_width-1:0] value;
        logic [4:0] op_code;
        active_channels = (index % max_channels) + 1;
        bus_write(channel_count_address, data_width'(active_channels - 1));
        for (int i = 0; i < register_count; i++) begin
            model_registers[i] = random_word();
            bus_write(register_base + bus_address_width'(i), model_registers[i]);
        end
        length = min_program_length +
                 int'(random_word() % (max_program_length - min_program_length + 1));
        for (int i = 0; i < length; i++) begin
            // Any opcode from nop to ldi
            op_code = 5'(random_word() % 10);
            value = random_word();
            program_words[i] = {op_code, value[26:0]};
            bus_write(store_base + bus_address_width'(i), program_words[i]);
        end
        value = random_word();
        program_words[length] = {5'(stop), value[26:0]};
        bus_write(store_base + bus_address_width'(length), program_words[length]);
        execute_model(length, active_channels);

        done_before = done_count;
        pulse_run();
        check_flag("busy", busy, 1'b1);
        // A second pulse while busy must be ignored
        if (index % 2 == 1) begin
            pulse_run();
        end
        bus_read(status_address, value);
        check_data("status", value, 32'd1);

        // Register access stalls until the run is over
        watched = int'(random_word() % register_count);
        bus_read(register_base + bus_address_width'(watched), value);
        if (done_count != done_before + 1) begin
            report_failure($sformatf("program %0d: register read acknowledged before done",
                                     index));
        end
        check_data($sformatf("register[%0d] after stall", watched), value,
                   model_registers[watched]);
        check_flag("busy", busy, 1'b0);
        bus_read(status_address, value);
        check_data("status", value, 32'd0);

        for (int i = 0; i < register_count; i++) begin
            bus_read(register_base + bus_address_width'(i), value);
            check_data($sformatf("program %0d register[%0d]", index, i), value,
                       model_registers[i]);
        end
        if (done_count != done_before + 1) begin
            report_failure($sformatf("program %0d: done pulsed %0d times instead of once",
                                     index, done_count - done_before));
        end
    endtask

    initial begin
        int total_errors;
        seed = 32'hb4a0_dfac;
        run = 1'b0;
        bus_request = '0;
        wait (reset == 1'b0);
        @(negedge clock);

        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
        bus_round_trip();
        for (int p = 0; p < program_count; p++) begin
            run_program(p);
        end

        total_errors = data_errors + store_errors + flag_errors + other_errors;
        $display("Error counts: data %0d, store %0d, flag %0d, other %0d, total %0d",
                 data_errors, store_errors, flag_errors, other_errors, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/core_pkg.sv
source/core_control_unit.sv
source/core_instruction_store.sv
source/core_decoder.sv
source/core_register_file.sv
source/core_alu.sv
source/core_bus_endpoint.sv
source/core_top.sv
testbench/core_clock_gen.sv
testbench/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
        --top-module core_tb -f filelist.f -o core_sim; then
    echo "Build failed"
    exit 1
fi

if ! ./obj_dir/core_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "All tests passed!" "$LOG"; then
    exit 0
else
    exit 1
fi
